/* sources.f */
hdl/tri_setup_pkg.sv
hdl/setup_sequencer.sv
hdl/vertex_sort.sv
hdl/slope_issue.sv
hdl/slope_divider.sv
hdl/slope_collect.sv
hdl/tri_setup_top.sv
testbench/tri_setup_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tri_setup_tb -o tri_setup_sim \
	&& ./obj_dir/tri_setup_sim | tee /dev/stderr | grep -q "Result: PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* testbench/tri_setup_tb.sv */
`timescale 1ns/10ps

module tri_setup_tb;
	import tri_setup_pkg::*;

	localparam int CLK_HALF   = 20;
	localparam int DRIVE_DLY  = 2;
	localparam int WAIT_LIMIT = 2000;                   // cycles per wait loop
	localparam int XR_LSB     = 3 * SLOPE_W + 3 * ROW_W;
	localparam int XL_LSB     = XR_LSB + COORD_W;

	logic      clk100;
	logic      rst_n;
	logic      next_frame;
	vtx_word_t vtx_data;
	logic      vtx_empty;
	logic      tri_wait;
	logic      vtx_pop;
	tri_word_t tri_data;
	logic      tri_push;

	vtx_word_t src_q [$];                               // vertex FIFO contents
	tri_word_t exp_q [$];                               // triangles in flight
	int        exp_pop_cyc [$];
	int        pop_log [$];
	tri_word_t last_word;
	int        last_pop_cyc;
	int        last_push_cyc;
	int        cyc;
	int        pop_cnt;
	int        push_cnt;
	logic      wait_req;
	logic      flush_req;
	integer    seed;

	tri_setup_top UUT (
		.clk100     (clk100),
		.rst_n      (rst_n),
		.next_frame (next_frame),
		.vtx_data   (vtx_data),
		.vtx_empty  (vtx_empty),
		.tri_wait   (tri_wait),
		.vtx_pop    (vtx_pop),
		.tri_data   (tri_data),
		.tri_push   (tri_push)
	);

	initial
	begin
		clk100 = 1'b0;
		forever
			#CLK_HALF clk100 = ~clk100;
	end

	//////////////////////////////////////////////////////////////////////
	// error handling and compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic compare_word(input string name, input tri_word_t got, input tri_word_t exp);
		if (got !== exp)
			stop_on_error($sformatf("Fail t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic compare_slope(input string name, input slope_t got, input slope_t exp);
		if (got !== exp)
			stop_on_error($sformatf("Fail t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		if (got != exp)
			stop_on_error($sformatf("Fail t=%0t %s got %0d expected %0d", $time, name, got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	// dx * 2^FRAC_W / dy, int division truncates toward zero
	function automatic slope_t ref_slope(input int dx, input int dy);
		if (dy == 0)
			return slope_t'(0);
		return slope_t'((dx * (1 << FRAC_W)) / dy);
	endfunction

	function automatic tri_word_t expected_word(input vtx_word_t w);
		coord_t x1;
		coord_t x2;
		coord_t x3;
		coord_t y1;
		coord_t y2;
		coord_t y3;
		int     x [3];
		int     y [3];
		int     ord [3];
		int     tmp;
		int     xr;
		{x1, x2, x3, y1, y2, y3} = w;
		x = '{int'(x1), int'(x2), int'(x3)};
		y = '{int'(y1), int'(y2), int'(y3)};
		ord = '{0, 1, 2};
		// bubble sort, strict compare so ties keep word order
		for (int p = 0; p < 2; p++)
		begin
			for (int j = 0; j < 2; j++)
			begin
				if (y[ord[j]] > y[ord[j+1]])
				begin
					tmp = ord[j];
					ord[j] = ord[j+1];
					ord[j+1] = tmp;
				end
			end
		end
		xr = ((y[ord[0]] >> 2) == (y[ord[1]] >> 2)) ? x[ord[1]] : x[ord[0]];  // flat top
		return {coord_t'(x[ord[0]]), coord_t'(xr),
			row_t'(y[ord[0]] >> 2), row_t'(y[ord[1]] >> 2), row_t'(y[ord[2]] >> 2),
			ref_slope(x[ord[2]] - x[ord[0]], y[ord[2]] - y[ord[0]]),
			ref_slope(x[ord[1]] - x[ord[0]], y[ord[1]] - y[ord[0]]),
			ref_slope(x[ord[2]] - x[ord[1]], y[ord[2]] - y[ord[1]])};
	endfunction

	function automatic vtx_word_t make_tri(input int x1, input int x2, input int x3,
		input int y1, input int y2, input int y3);
		return {coord_t'(x1), coord_t'(x2), coord_t'(x3), coord_t'(y1), coord_t'(y2), coord_t'(y3)};
	endfunction

	function automatic vtx_word_t random_tri();
		vtx_word_t w;
		for (int i = 0; i < 6; i++)
			w[i*COORD_W +: COORD_W] = coord_t'($random(seed));
		return w;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// source FIFO driver and output monitor
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		vtx_data   = '0;
		vtx_empty  = 1'b1;
		tri_wait   = 1'b0;
		next_frame = 1'b0;
		forever
		begin
			@(posedge clk100);
			#DRIVE_DLY;
			vtx_empty = (src_q.size() == 0);
			if (src_q.size() != 0)
				vtx_data = src_q[0];              // show-ahead
			tri_wait   = wait_req;
			next_frame = flush_req;
		end
	end

	// mid-cycle sampling, all DUT outputs settled
	initial
	begin
		cyc = 0;
		pop_cnt = 0;
		push_cnt = 0;
		last_pop_cyc = 0;
		last_push_cyc = 0;
		last_word = '0;
		forever
		begin
			@(negedge clk100);
			cyc++;
			if (tri_push)
			begin
				if (exp_q.size() == 0)
					stop_on_error("tri_push with no triangle in flight");
				compare_word("tri_data", tri_data, exp_q.pop_front());
				compare_count("pop_to_push", cyc - exp_pop_cyc.pop_front(), POP_TO_PUSH);
				last_word = tri_data;
				last_push_cyc = cyc;
				push_cnt++;
			end
			if (vtx_pop)
			begin
				if (vtx_empty || src_q.size() == 0)
					stop_on_error("vtx_pop while the vertex FIFO is empty");
				if (tri_wait)
					stop_on_error("vtx_pop while tri_wait is high");
				exp_q.push_back(expected_word(src_q.pop_front()));
				exp_pop_cyc.push_back(cyc);
				pop_log.push_back(cyc);
				last_pop_cyc = cyc;
				pop_cnt++;
			end
			if (next_frame)
			begin
				exp_q.delete();                   // flushed triangles never come out
				exp_pop_cyc.delete();
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// wait helpers, each bounded
	//////////////////////////////////////////////////////////////////////

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk100);
			#1;
		end
	endtask

	task automatic wait_pops(input int target);
		int n;
		n = 0;
		while (pop_cnt < target)
		begin
			if (n == WAIT_LIMIT)
				stop_on_error("timeout waiting for vertex FIFO pops");
			idle_cycles(1);
			n++;
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (src_q.size() != 0 || exp_q.size() != 0)
		begin
			if (n == WAIT_LIMIT)
				stop_on_error("timeout waiting for the pipeline to drain");
			idle_cycles(1);
			n++;
		end
	endtask

	task automatic run_one(input vtx_word_t w);
		src_q.push_back(w);
		wait_drained();
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	task automatic single_triangle();
		int base;
		base = push_cnt;
		run_one(make_tri(100, 40, 300, 20, 200, 400));
		compare_count("push_count", push_cnt - base, 1);
		compare_count("pop_to_push", last_push_cyc - last_pop_cyc, POP_TO_PUSH);
	endtask

	task automatic all_orderings();
		int base;
		base = push_cnt;
		src_q.push_back(make_tri(700, 1500, 3000, 10, 200, 400));
		src_q.push_back(make_tri(700, 1500, 3000, 10, 400, 200));
		src_q.push_back(make_tri(700, 1500, 3000, 200, 10, 400));
		src_q.push_back(make_tri(700, 1500, 3000, 400, 10, 200));
		src_q.push_back(make_tri(700, 1500, 3000, 200, 400, 10));
		src_q.push_back(make_tri(700, 1500, 3000, 400, 200, 10));
		src_q.push_back(make_tri(700, 1500, 3000, 120, 120, 300));
		src_q.push_back(make_tri(700, 1500, 3000, 120, 300, 120));
		src_q.push_back(make_tri(700, 1500, 3000, 250, 250, 250));
		src_q.push_back(make_tri(700, 1500, 3000, 300, 120, 120));
		wait_drained();
		compare_count("push_count", push_cnt - base, 10);
		// last one: tie on top, vertex 2 before vertex 3
		compare_count("x_left_start", int'(last_word[XL_LSB +: COORD_W]), 1500);
		compare_count("x_right_start", int'(last_word[XR_LSB +: COORD_W]), 3000);
	endtask

	task automatic flat_and_degenerate();
		run_one(make_tri(50, 400, 200, 100, 101, 300));
		compare_count("x_right_start", int'(last_word[XR_LSB +: COORD_W]), 400);
		run_one(make_tri(10, 2000, 4000, 600, 600, 600));   // all dy zero
		compare_count("x_right_start", int'(last_word[XR_LSB +: COORD_W]), 2000);
		compare_slope("m_long", last_word[2*SLOPE_W +: SLOPE_W], slope_t'(0));
		compare_slope("m_top", last_word[SLOPE_W +: SLOPE_W], slope_t'(0));
		compare_slope("m_bottom", last_word[0 +: SLOPE_W], slope_t'(0));
		run_one(make_tri(900, 100, 3000, 50, 900, 900));     // flat bottom
		compare_count("x_right_start", int'(last_word[XR_LSB +: COORD_W]), 900);
		compare_slope("m_bottom", last_word[0 +: SLOPE_W], slope_t'(0));
	endtask

	task automatic random_stream();
		int base_pop;
		int base_push;
		base_pop = pop_cnt;
		base_push = push_cnt;
		for (int i = 0; i < 40; i++)
			src_q.push_back(random_tri());
		wait_drained();
		compare_count("pop_count", pop_cnt - base_pop, 40);
		compare_count("push_count", push_cnt - base_push, 40);
		for (int i = base_pop + 1; i < pop_cnt; i++)
			compare_count("pop_spacing", pop_log[i] - pop_log[i-1], SLOT_CYCLES);
	endtask

	task automatic wait_hold();
		int held_pops;
		for (int i = 0; i < 12; i++)
			src_q.push_back(random_tri());
		wait_pops(pop_cnt + 3);
		wait_req = 1'b1;
		held_pops = pop_cnt;
		idle_cycles(POP_TO_PUSH + 2 * SLOT_CYCLES);   // longer than any triangle in flight
		compare_count("pops_while_waiting", pop_cnt - held_pops, 0);
		compare_count("in_flight_after_wait", exp_q.size(), 0);
		wait_req = 1'b0;
		wait_drained();
	endtask

	task automatic frame_flush();
		int flushed_pushes;
		int resume_pops;
		for (int i = 0; i < 6; i++)
			src_q.push_back(random_tri());
		wait_pops(pop_cnt + 3);
		idle_cycles(5);
		flush_req = 1'b1;
		wait_req = 1'b1;                              // keep the source quiet while checking
		idle_cycles(1);
		flush_req = 1'b0;
		flushed_pushes = push_cnt;
		idle_cycles(POP_TO_PUSH);
		compare_count("pushes_after_flush", push_cnt - flushed_pushes, 0);
		resume_pops = pop_cnt;
		wait_req = 1'b0;
		wait_drained();
		compare_count("push_count_after_resume", push_cnt - flushed_pushes, pop_cnt - resume_pops);
	endtask

	initial
	begin
		seed = 32'h560e;
		rst_n = 1'b0;
		wait_req = 1'b0;
		flush_req = 1'b0;
		repeat (8) @(posedge clk100);
		#DRIVE_DLY;
		rst_n = 1'b1;
		idle_cycles(1);
		single_triangle();
		all_orderings();
		flat_and_degenerate();
		random_stream();
		wait_hold();
		frame_flush();
		if (exp_q.size() != 0 || src_q.size() != 0)
			stop_on_error("triangles left over at the end of the run");
		else
		begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

/* hdl/tri_setup_top.sv */
`timescale 1ns/10ps

module tri_setup_top (
	input  logic                     clk100,
	input  logic                     rst_n,
	input  logic                     next_frame,
	input  tri_setup_pkg::vtx_word_t vtx_data,
	input  logic                     vtx_empty,
	input  logic                     tri_wait,
	output logic                     vtx_pop,
	output tri_setup_pkg::tri_word_t tri_data,
	output logic                     tri_push
);
	import tri_setup_pkg::*;

	phase_t   phase;
	logic     sort_valid;
	coord_t   x_top;
	coord_t   x_mid;
	coord_t   x_bot;
	coord_t   y_top;
	coord_t   y_mid;
	coord_t   y_bot;
	logic     div_valid;
	delta_t   div_dividend;
	delta_t   div_divisor;
	edge_t    div_edge;
	tri_hdr_t div_hdr;
	logic     res_valid;
	slope_t   res_slope;
	edge_t    res_edge;
	tri_hdr_t res_hdr;

	setup_sequencer u_seq (
		.clk100     (clk100),
		.rst_n      (rst_n),
		.next_frame (next_frame),
		.vtx_empty  (vtx_empty),
		.tri_wait   (tri_wait),
		.phase      (phase),
		.vtx_pop    (vtx_pop)
	);

	vertex_sort u_sort (
		.clk100     (clk100),
		.rst_n      (rst_n),
		.next_frame (next_frame),
		.vtx_pop    (vtx_pop),
		.vtx_data   (vtx_data),
		.sort_valid (sort_valid),
		.x_top      (x_top),
		.x_mid      (x_mid),
		.x_bot      (x_bot),
		.y_top      (y_top),
		.y_mid      (y_mid),
		.y_bot      (y_bot)
	);

	slope_issue u_issue (
		.clk100       (clk100),
		.rst_n        (rst_n),
		.next_frame   (next_frame),
		.phase        (phase),
		.sort_valid   (sort_valid),
		.x_top        (x_top),
		.x_mid        (x_mid),
		.x_bot        (x_bot),
		.y_top        (y_top),
		.y_mid        (y_mid),
		.y_bot        (y_bot),
		.div_valid    (div_valid),
		.div_dividend (div_dividend),
		.div_divisor  (div_divisor),
		.div_edge     (div_edge),
		.div_hdr      (div_hdr)
	);

	// shared divider, header rides along as side data
	slope_divider #(
		.QUOT_BITS (QUOT_BITS),
		.SIDE_W    (HDR_W)
	) u_div (
		.clk100     (clk100),
		.rst_n      (rst_n),
		.next_frame (next_frame),
		.in_valid   (div_valid),
		.dividend   (div_dividend),
		.divisor    (div_divisor),
		.in_edge    (div_edge),
		.in_side    (div_hdr),
		.out_valid  (res_valid),
		.quotient   (res_slope),
		.out_edge   (res_edge),
		.out_side   (res_hdr)
	);

	slope_collect u_collect (
		.clk100     (clk100),
		.rst_n      (rst_n),
		.next_frame (next_frame),
		.res_valid  (res_valid),
		.res_slope  (res_slope),
		.res_edge   (res_edge),
		.res_hdr    (res_hdr),
		.tri_data   (tri_data),
		.tri_push   (tri_push)
	);

endmodule

/* hdl/slope_collect.sv */
`timescale 1ns/10ps

module slope_collect (
	input  logic                     clk100,
	input  logic                     rst_n,
	input  logic                     next_frame,
	input  logic                     res_valid,
	input  tri_setup_pkg::slope_t    res_slope,
	input  tri_setup_pkg::edge_t     res_edge,
	input  tri_setup_pkg::tri_hdr_t  res_hdr,
	output tri_setup_pkg::tri_word_t tri_data,
	output logic                     tri_push
);
	import tri_setup_pkg::*;

	slope_t m_long;
	slope_t m_top;

	// results of one triangle arrive on three consecutive cycles
	always_ff @(posedge clk100)
	begin
		if (res_valid)
		begin
			case (res_edge)
				EDGE_LONG:   m_long <= res_slope;
				EDGE_TOP:    m_top <= res_slope;
				EDGE_BOTTOM: tri_data <= {res_hdr, m_long, m_top, res_slope};
				default:     ;
			endcase
		end
	end

	// push strobe, no back-pressure from the output FIFO
	always_ff @(posedge clk100 or negedge rst_n)
	begin
		if (!rst_n)
			tri_push <= 1'b0;
		else if (next_frame)
			tri_push <= 1'b0;
		else
			tri_push <= res_valid && (res_edge == EDGE_BOTTOM);
	end

endmodule

/* hdl/slope_divider.sv */
`timescale 1ns/10ps

module slope_divider #(
	parameter int QUOT_BITS = tri_setup_pkg::QUOT_BITS,
	parameter int SIDE_W    = tri_setup_pkg::HDR_W
) (
	input  logic                  clk100,
	input  logic                  rst_n,
	input  logic                  next_frame,
	input  logic                  in_valid,
	input  tri_setup_pkg::delta_t dividend,
	input  tri_setup_pkg::delta_t divisor,
	input  tri_setup_pkg::edge_t  in_edge,
	input  logic [SIDE_W-1:0]     in_side,
	output logic                  out_valid,
	output tri_setup_pkg::slope_t quotient,
	output tri_setup_pkg::edge_t  out_edge,
	output logic [SIDE_W-1:0]     out_side
);
	import tri_setup_pkg::*;

	localparam int MAG_W = $bits(delta_t);

	logic [MAG_W-1:0]     mag_dvd;
	logic [MAG_W-1:0]     mag_dvs;
	logic [QUOT_BITS-1:0] num_in;

	// stage registers, the last stage writes the outputs instead
	logic                 st_valid [QUOT_BITS-1];
	edge_t                st_edge  [QUOT_BITS-1];
	logic [SIDE_W-1:0]    st_side  [QUOT_BITS-1];
	logic [MAG_W-1:0]     st_rem   [QUOT_BITS-1];
	logic [QUOT_BITS-1:0] st_num   [QUOT_BITS-1];  // numerator in, quotient bits shift in
	logic [MAG_W-1:0]     st_dvs   [QUOT_BITS-1];
	logic                 st_neg   [QUOT_BITS-1];

	assign mag_dvd = dividend[MAG_W-1] ? (~dividend + 1'b1) : dividend;
	assign mag_dvs = divisor[MAG_W-1] ? (~divisor + 1'b1) : divisor;
	assign num_in  = QUOT_BITS'({mag_dvd, {FRAC_W{1'b0}}});   // scale to 10 fraction bits

	//////////////////////////////////////////////////////////////////////
	// restoring chain, one quotient bit per stage
	//////////////////////////////////////////////////////////////////////

	for (genvar k = 0; k < QUOT_BITS; k++)
	begin : g_stage
		logic                 p_valid;
		edge_t                p_edge;
		logic [SIDE_W-1:0]    p_side;
		logic [MAG_W-1:0]     p_rem;
		logic [QUOT_BITS-1:0] p_num;
		logic [MAG_W-1:0]     p_dvs;
		logic                 p_neg;
		logic [MAG_W:0]       trial;
		logic                 q_bit;
		logic [MAG_W-1:0]     n_rem;
		logic [QUOT_BITS-1:0] n_num;

		if (k == 0)
		begin : g_head
			assign p_valid = in_valid;
			assign p_edge  = in_edge;
			assign p_side  = in_side;
			assign p_rem   = '0;
			assign p_num   = num_in;
			assign p_dvs   = mag_dvs;
			assign p_neg   = dividend[MAG_W-1] ^ divisor[MAG_W-1];
		end
		else
		begin : g_link
			assign p_valid = st_valid[k-1];
			assign p_edge  = st_edge[k-1];
			assign p_side  = st_side[k-1];
			assign p_rem   = st_rem[k-1];
			assign p_num   = st_num[k-1];
			assign p_dvs   = st_dvs[k-1];
			assign p_neg   = st_neg[k-1];
		end

		assign trial = {p_rem, p_num[QUOT_BITS-1]};       // bring down next bit
		assign q_bit = trial >= {1'b0, p_dvs};
		assign n_rem = MAG_W'(q_bit ? (trial - {1'b0, p_dvs}) : trial);
		assign n_num = {p_num[QUOT_BITS-2:0], q_bit};

		if (k < QUOT_BITS - 1)
		begin : g_mid
			always_ff @(posedge clk100 or negedge rst_n)
			begin
				if (!rst_n)
					st_valid[k] <= 1'b0;
				else if (next_frame)
					st_valid[k] <= 1'b0;
				else
					st_valid[k] <= p_valid;
			end

			always_ff @(posedge clk100)
			begin
				st_edge[k] <= p_edge;
				st_side[k] <= p_side;
				st_rem[k]  <= n_rem;
				st_num[k]  <= n_num;
				st_dvs[k]  <= p_dvs;
				st_neg[k]  <= p_neg;
			end
		end
		else
		begin : g_last
			always_ff @(posedge clk100 or negedge rst_n)
			begin
				if (!rst_n)
					out_valid <= 1'b0;
				else if (next_frame)
					out_valid <= 1'b0;
				else
					out_valid <= p_valid;
			end

			// dy = 0 gives a flat slope
			always_ff @(posedge clk100)
			begin
				out_edge <= p_edge;
				out_side <= p_side;
				if (p_dvs == '0)
					quotient <= '0;
				else if (p_neg)
					quotient <= -slope_t'(n_num);
				else
					quotient <= slope_t'(n_num);
			end
		end
	end

endmodule

/* hdl/slope_issue.sv */
`timescale 1ns/10ps

module slope_issue (
	input  logic                    clk100,
	input  logic                    rst_n,
	input  logic                    next_frame,
	input  tri_setup_pkg::phase_t   phase,
	input  logic                    sort_valid,
	input  tri_setup_pkg::coord_t   x_top,
	input  tri_setup_pkg::coord_t   x_mid,
	input  tri_setup_pkg::coord_t   x_bot,
	input  tri_setup_pkg::coord_t   y_top,
	input  tri_setup_pkg::coord_t   y_mid,
	input  tri_setup_pkg::coord_t   y_bot,
	output logic                    div_valid,
	output tri_setup_pkg::delta_t   div_dividend,
	output tri_setup_pkg::delta_t   div_divisor,
	output tri_setup_pkg::edge_t    div_edge,
	output tri_setup_pkg::tri_hdr_t div_hdr
);
	import tri_setup_pkg::*;

	delta_t   dx_long;
	delta_t   dy_long;
	delta_t   dx_top;
	delta_t   dy_top;
	delta_t   dx_bot;
	delta_t   dy_bot;
	row_t     row_top;
	row_t     row_mid;
	row_t     row_end;
	coord_t   x_right;
	tri_hdr_t hdr;
	logic     slot_live;
	logic     issue;

	//////////////////////////////////////////////////////////////////////
	// edge deltas, zero extended so the difference fits delta_t
	//////////////////////////////////////////////////////////////////////

	assign dx_long = {1'b0, x_bot} - {1'b0, x_top};
	assign dy_long = {1'b0, y_bot} - {1'b0, y_top};
	assign dx_top  = {1'b0, x_mid} - {1'b0, x_top};
	assign dy_top  = {1'b0, y_mid} - {1'b0, y_top};
	assign dx_bot  = {1'b0, x_bot} - {1'b0, x_mid};
	assign dy_bot  = {1'b0, y_bot} - {1'b0, y_mid};

	// coarse rows
	assign row_top = y_top[COORD_W-1:2];
	assign row_mid = y_mid[COORD_W-1:2];
	assign row_end = y_bot[COORD_W-1:2];

	// flat top starts the right edge at the mid vertex
	assign x_right = (row_top == row_mid) ? x_mid : x_top;
	assign hdr     = {x_top, x_right, row_top, row_mid, row_end};

	// sort_valid only lasts the long cycle, slot_live covers the rest
	assign issue = (phase == PH_LONG) ? sort_valid : ((phase != PH_FETCH) && slot_live);

	always_ff @(posedge clk100 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			slot_live <= 1'b0;
			div_valid <= 1'b0;
		end
		else if (next_frame)
		begin
			slot_live <= 1'b0;
			div_valid <= 1'b0;
		end
		else
		begin
			if (phase == PH_LONG)
				slot_live <= sort_valid;
			div_valid <= issue;
		end
	end

	// one division per phase
	always_ff @(posedge clk100)
	begin
		if (issue)
		begin
			case (phase)
				PH_LONG:
				begin
					div_dividend <= dx_long;
					div_divisor  <= dy_long;
					div_edge     <= EDGE_LONG;
				end
				PH_TOP:
				begin
					div_dividend <= dx_top;
					div_divisor  <= dy_top;
					div_edge     <= EDGE_TOP;
				end
				default:                    // PH_BOTTOM, fetch never issues
				begin
					div_dividend <= dx_bot;
					div_divisor  <= dy_bot;
					div_edge     <= EDGE_BOTTOM;
				end
			endcase
			div_hdr <= hdr;
		end
	end

endmodule

/* hdl/vertex_sort.sv */
`timescale 1ns/10ps

module vertex_sort (
	input  logic                     clk100,
	input  logic                     rst_n,
	input  logic                     next_frame,
	input  logic                     vtx_pop,
	input  tri_setup_pkg::vtx_word_t vtx_data,
	output logic                     sort_valid,
	output tri_setup_pkg::coord_t    x_top,
	output tri_setup_pkg::coord_t    x_mid,
	output tri_setup_pkg::coord_t    x_bot,
	output tri_setup_pkg::coord_t    y_top,
	output tri_setup_pkg::coord_t    y_mid,
	output tri_setup_pkg::coord_t    y_bot
);
	import tri_setup_pkg::*;

	coord_t     vx [3];
	coord_t     vy [3];
	logic       a_le_b;
	logic       a_le_c;
	logic       b_le_c;
	logic [1:0] i_top;
	logic [1:0] i_mid;
	logic [1:0] i_bot;

	// unpack, vertex 1 sits highest in the word
	always_comb
	begin
		for (int i = 0; i < 3; i++)
		begin
			vx[i] = vtx_data[(5-i)*COORD_W +: COORD_W];
			vy[i] = vtx_data[(2-i)*COORD_W +: COORD_W];
		end
	end

	assign a_le_b = vy[0] <= vy[1];
	assign a_le_c = vy[0] <= vy[2];
	assign b_le_c = vy[1] <= vy[2];

	// pick one of six orders; <= keeps equal y in input order
	always_comb
	begin
		case ({a_le_b, a_le_c, b_le_c})
			3'b111:  {i_top, i_mid, i_bot} = {2'd0, 2'd1, 2'd2};
			3'b110:  {i_top, i_mid, i_bot} = {2'd0, 2'd2, 2'd1};
			3'b011:  {i_top, i_mid, i_bot} = {2'd1, 2'd0, 2'd2};
			3'b100:  {i_top, i_mid, i_bot} = {2'd2, 2'd0, 2'd1};
			3'b001:  {i_top, i_mid, i_bot} = {2'd1, 2'd2, 2'd0};
			3'b000:  {i_top, i_mid, i_bot} = {2'd2, 2'd1, 2'd0};
			default: {i_top, i_mid, i_bot} = {2'd0, 2'd1, 2'd2};  // 010/101 cannot occur
		endcase
	end

	always_ff @(posedge clk100 or negedge rst_n)
	begin
		if (!rst_n)
			sort_valid <= 1'b0;
		else if (next_frame)
			sort_valid <= 1'b0;
		else
			sort_valid <= vtx_pop;
	end

	// held until the next pop, slope_issue reads it for three cycles
	always_ff @(posedge clk100)
	begin
		if (vtx_pop)
		begin
			x_top <= vx[i_top];
			x_mid <= vx[i_mid];
			x_bot <= vx[i_bot];
			y_top <= vy[i_top];
			y_mid <= vy[i_mid];
			y_bot <= vy[i_bot];
		end
	end

endmodule

/* hdl/setup_sequencer.sv */
`timescale 1ns/10ps

module setup_sequencer (
	input  logic                  clk100,
	input  logic                  rst_n,
	input  logic                  next_frame,
	input  logic                  vtx_empty,
	input  logic                  tri_wait,
	output tri_setup_pkg::phase_t phase,
	output logic                  vtx_pop
);
	import tri_setup_pkg::*;

	// one triangle slot every four cycles, fetch first
	always_ff @(posedge clk100 or negedge rst_n)
	begin
		if (!rst_n)
			phase <= PH_FETCH;
		else if (next_frame)
			phase <= PH_FETCH;          // restart slot on frame flush
		else
			phase <= phase_t'(phase + 2'd1);  // wraps PH_BOTTOM -> PH_FETCH
	end

	// wait and empty only matter in the fetch cycle
	// no fetch while the frame flushes, the word would be dropped
	assign vtx_pop = (phase == PH_FETCH) && !vtx_empty && !tri_wait && !next_frame;

endmodule

/* hdl/tri_setup_pkg.sv */
package tri_setup_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths and latencies
	//////////////////////////////////////////////////////////////////////

	localparam int COORD_W     = 12;
	localparam int ROW_W       = 10;                    // y without its two low bits
	localparam int FRAC_W      = 10;
	localparam int SLOPE_W     = 24;                    // signed 13.10 plus headroom
	localparam int QUOT_BITS   = 23;                    // 13 bit magnitude << FRAC_W
	localparam int DIV_LATENCY = QUOT_BITS + 1;         // issue register + divider stages
	localparam int SLOT_CYCLES = 4;
	localparam int POP_TO_PUSH = DIV_LATENCY + 4;
	localparam int HDR_W       = 2 * COORD_W + 3 * ROW_W;

	//////////////////////////////////////////////////////////////////////
	// vector types
	//////////////////////////////////////////////////////////////////////

	typedef logic [COORD_W-1:0] coord_t;
	typedef logic [ROW_W-1:0] row_t;
	typedef logic [COORD_W:0] delta_t;                  // two's complement difference
	typedef logic [SLOPE_W-1:0] slope_t;

	// x1 x2 x3 y1 y2 y3, x1 in the MSBs
	typedef logic [6*COORD_W-1:0] vtx_word_t;

	// x_left_start, x_right_start, y_top_row, y_mid_row, y_end_row
	typedef logic [HDR_W-1:0] tri_hdr_t;

	// header, m_long, m_top, m_bottom
	typedef logic [HDR_W+3*SLOPE_W-1:0] tri_word_t;

	//////////////////////////////////////////////////////////////////////
	// enums
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		PH_FETCH,
		PH_LONG,
		PH_TOP,
		PH_BOTTOM
	} phase_t;

	typedef enum logic [1:0] {
		EDGE_LONG,
		EDGE_TOP,
		EDGE_BOTTOM
	} edge_t;

endpackage
